//--- Makefile
# Verilator build and run for the FP slice testbench

VERILATOR ?= verilator
TOP       ?= fpslice_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/fpslice_dispatch.sv
// Input side of the FP slice; splits operands into lanes and issues both lane requests
`timescale 1ns/1ps
`default_nettype none

`include "fpslice_macros.svh"

module fpslice_dispatch (
  input  wire logic [`FPS_WIDTH-1:0]     operand_a_i,
  input  wire logic [`FPS_WIDTH-1:0]     operand_b_i,
  input  wire fpslice_pkg::operation_e   op_i,
  input  wire fpslice_pkg::fp_format_e   fmt_i,
  input  wire logic                      vector_i,
  input  wire logic [`FPS_TAG_WIDTH-1:0] tag_i,
  input  wire logic                      in_valid_i,
  output logic                           in_ready_o,
  fpslice_lane_req_if.source             lane0_o,
  fpslice_lane_req_if.source             lane1_o
);

  localparam int unsigned HW = `FPS_HALF_WIDTH;

  logic                   is_fp16;
  logic                   vector_eff;
  logic                   a_boxed;
  logic                   b_boxed;
  logic [HW-1:0]          a_low;
  logic [HW-1:0]          b_low;
  fpslice_pkg::lane_aux_t aux;

  // Vectors only exist for FP16, FP32 with the vector flag runs as scalar
  assign is_fp16    = (fmt_i == fpslice_pkg::FP16);
  assign vector_eff = vector_i & is_fp16;

  // Upstream ready follows lane 0
  assign in_ready_o = lane0_o.ready;

  // ----------------------------------------
  // FP16 boxing check
  // ----------------------------------------
  assign a_boxed = &operand_a_i[`FPS_WIDTH-1:HW];
  assign b_boxed = &operand_b_i[`FPS_WIDTH-1:HW];

  // An unboxed scalar operand reads as the canonical NaN
  assign a_low = (vector_eff || a_boxed) ? operand_a_i[HW-1:0] : `FPS_QNAN16;
  assign b_low = (vector_eff || b_boxed) ? operand_b_i[HW-1:0] : `FPS_QNAN16;

  assign aux.fmt    = fmt_i;
  assign aux.vector = vector_eff;

  // ----------------------------------------
  // Lane 0: full word or low halves
  // ----------------------------------------
  assign lane0_o.valid     = in_valid_i;
  assign lane0_o.operand_a = is_fp16 ? {{HW{1'b0}}, a_low} : operand_a_i;
  assign lane0_o.operand_b = is_fp16 ? {{HW{1'b0}}, b_low} : operand_b_i;
  assign lane0_o.op        = op_i;
  assign lane0_o.fmt       = fmt_i;
  assign lane0_o.aux       = aux;
  assign lane0_o.tag       = tag_i;

  // ----------------------------------------
  // Lane 1: high halves, vectors only
  // ----------------------------------------
  assign lane1_o.valid     = in_valid_i & vector_eff;
  assign lane1_o.operand_a = {{HW{1'b0}}, operand_a_i[`FPS_WIDTH-1:HW]};
  assign lane1_o.operand_b = {{HW{1'b0}}, operand_b_i[`FPS_WIDTH-1:HW]};
  assign lane1_o.op        = op_i;
  assign lane1_o.fmt       = fpslice_pkg::FP16;
  assign lane1_o.aux       = aux;
  assign lane1_o.tag       = tag_i;

endmodule

`default_nettype wire

//--- logic/fpslice_if.sv
// Lane request and response handshake bundles used between dispatcher, lanes and packer
`timescale 1ns/1ps
`default_nettype none

`include "fpslice_macros.svh"

// One operation going into a lane
interface fpslice_lane_req_if;
  logic                          valid;
  logic                          ready;
  logic [`FPS_WIDTH-1:0]         operand_a;
  logic [`FPS_WIDTH-1:0]         operand_b;
  fpslice_pkg::operation_e       op;
  fpslice_pkg::fp_format_e       fmt;
  fpslice_pkg::lane_aux_t        aux;
  logic [`FPS_TAG_WIDTH-1:0]     tag;

  modport source (output valid, operand_a, operand_b, op, fmt, aux, tag, input ready);
  modport sink   (input valid, operand_a, operand_b, op, fmt, aux, tag, output ready);
endinterface

// One result leaving a lane, plus the lane's occupancy summary
interface fpslice_lane_rsp_if;
  logic                          valid;
  logic                          ready;
  logic [`FPS_WIDTH-1:0]         result;
  fpslice_pkg::status_t          status;
  fpslice_pkg::lane_aux_t        aux;
  logic [`FPS_TAG_WIDTH-1:0]     tag;
  // Any stage of the lane holds a valid item
  logic                          busy;

  modport source (output valid, result, status, aux, tag, busy, input ready);
  modport sink   (input valid, result, status, aux, tag, busy, output ready);
endinterface

`default_nettype wire

//--- logic/fpslice_lane.sv
// One FP slice lane; sign injection and min/max followed by an elastic register pipeline
`timescale 1ns/1ps
`default_nettype none

`include "fpslice_macros.svh"

module fpslice_lane #(
  // Lane 0 handles FP32 as well and upper lanes are FP16 only
  parameter bit Fp32Capable = 1'b1
) (
  input  wire logic         clk_i,
  input  wire logic         arst_n_i,
  input  wire logic         flush_i,
  fpslice_lane_req_if.sink  req_i,
  fpslice_lane_rsp_if.source rsp_o
);

  localparam int unsigned N  = `FPS_PIPE_REGS;
  localparam int unsigned W  = `FPS_WIDTH;
  localparam int unsigned TW = `FPS_TAG_WIDTH;

  // ----------------------------------------
  // Operand helpers
  // ----------------------------------------
  function automatic logic sign_of(input logic [W-1:0] val, input logic half);
    return half ? val[15] : val[31];
  endfunction

  function automatic logic [W-2:0] mag_of(input logic [W-1:0] val, input logic half);
    return half ? {16'b0, val[14:0]} : val[W-2:0];
  endfunction

  // Returns {signalling, quiet}
  function automatic logic [1:0] nan_class(input logic [W-1:0] val, input logic half);
    logic exp_ones;
    logic quiet;
    logic frac_nz;
    if (half) begin
      exp_ones = &val[14:10];
      quiet    = val[9];
      frac_nz  = |val[8:0];
    end else begin
      exp_ones = &val[30:23];
      quiet    = val[22];
      frac_nz  = |val[21:0];
    end
    return {exp_ones & ~quiet & frac_nz, exp_ones & quiet};
  endfunction

  // Zero-extended result in the active format
  function automatic logic [W-1:0] build(input logic sgn, input logic [W-2:0] mag,
                                         input logic half);
    return half ? {16'b0, sgn, mag[14:0]} : {sgn, mag};
  endfunction

  logic                 is16;
  logic                 sign_a;
  logic                 sign_b;
  logic [W-2:0]         mag_a;
  logic [W-2:0]         mag_b;
  logic [1:0]           cls_a;
  logic [1:0]           cls_b;
  logic                 nan_a;
  logic                 nan_b;
  logic                 a_lt_b;
  logic [W-1:0]         canon_nan;
  logic [W-1:0]         op_result;
  fpslice_pkg::status_t op_status;

  assign is16 = !Fp32Capable || (req_i.fmt == fpslice_pkg::FP16);

  assign sign_a = sign_of(req_i.operand_a, is16);
  assign sign_b = sign_of(req_i.operand_b, is16);
  assign mag_a  = mag_of(req_i.operand_a, is16);
  assign mag_b  = mag_of(req_i.operand_b, is16);
  assign cls_a  = nan_class(req_i.operand_a, is16);
  assign cls_b  = nan_class(req_i.operand_b, is16);
  assign nan_a  = |cls_a;
  assign nan_b  = |cls_b;

  assign canon_nan = is16 ? {16'b0, `FPS_QNAN16} : `FPS_QNAN32;

  // Sign-magnitude order also puts -0 below +0
  always_comb begin
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = (mag_a > mag_b);
    end else begin
      a_lt_b = (mag_a < mag_b);
    end
  end

  // ----------------------------------------
  // Operation
  // ----------------------------------------
  always_comb begin
    op_status = '0;
    case (req_i.op)
      fpslice_pkg::SGNJ:  op_result = build(sign_b, mag_a, is16);
      fpslice_pkg::SGNJN: op_result = build(~sign_b, mag_a, is16);
      fpslice_pkg::SGNJX: op_result = build(sign_a ^ sign_b, mag_a, is16);
      fpslice_pkg::MIN, fpslice_pkg::MAX: begin
        op_status.nv = cls_a[1] | cls_b[1];
        if (nan_a && nan_b) begin
          op_result = canon_nan;
        end else if (nan_a) begin
          op_result = build(sign_b, mag_b, is16);
        end else if (nan_b) begin
          op_result = build(sign_a, mag_a, is16);
        end else if (a_lt_b == (req_i.op == fpslice_pkg::MIN)) begin
          op_result = build(sign_a, mag_a, is16);
        end else begin
          op_result = build(sign_b, mag_b, is16);
        end
      end
      default: op_result = canon_nan;
    endcase
  end

  // ----------------------------------------
  // Elastic pipeline
  // ----------------------------------------
  // Index i holds the item after i register stages
  logic [N:0]                       stage_valid;
  logic [N:0]                       stage_ready;
  logic [N:0][W-1:0]                stage_result;
  fpslice_pkg::status_t [N:0]       stage_status;
  fpslice_pkg::lane_aux_t [N:0]     stage_aux;
  logic [N:0][TW-1:0]               stage_tag;

  assign stage_valid[0]  = req_i.valid;
  assign stage_result[0] = op_result;
  assign stage_status[0] = op_status;
  assign stage_aux[0]    = req_i.aux;
  assign stage_tag[0]    = req_i.tag;

  for (genvar i = 0; i < N; i++) begin : gen_stage
    logic load;

    // Advance when downstream takes the item or holds a bubble
    assign stage_ready[i] = rsp_o.ready | ~&stage_valid[N:i+1];
    assign load           = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (flush_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        stage_result[i+1] <= stage_result[i];
        stage_status[i+1] <= stage_status[i];
        stage_aux[i+1]    <= stage_aux[i];
        stage_tag[i+1]    <= stage_tag[i];
      end
    end
  end

  assign stage_ready[N] = rsp_o.ready;
  assign req_i.ready    = stage_ready[0];

  assign rsp_o.valid  = stage_valid[N];
  assign rsp_o.result = stage_result[N];
  assign rsp_o.status = stage_status[N];
  assign rsp_o.aux    = stage_aux[N];
  assign rsp_o.tag    = stage_tag[N];
  assign rsp_o.busy   = |stage_valid[N:1];

endmodule

`default_nettype wire

//--- logic/fpslice_macros.svh
// Shared sizes and constant patterns for the FP slice; include wherever a width is needed
`ifndef FPSLICE_MACROS_SVH
`define FPSLICE_MACROS_SVH

// Datapath and lane geometry
`define FPS_WIDTH       32
`define FPS_HALF_WIDTH  16
`define FPS_NUM_LANES   2

// Register stages in each lane
`define FPS_PIPE_REGS   2

// Operation tag carried alongside the data
`define FPS_TAG_WIDTH   8

// Canonical quiet NaN patterns (RISC-V)
`define FPS_QNAN32      32'h7fc0_0000
`define FPS_QNAN16      16'h7e00

`endif

//--- logic/fpslice_pack.sv
// Output side of the FP slice; merges lane results into one word, flags and handshake
`timescale 1ns/1ps
`default_nettype none

`include "fpslice_macros.svh"

module fpslice_pack (
  fpslice_lane_rsp_if.sink               lane0_i,
  fpslice_lane_rsp_if.sink               lane1_i,
  input  wire logic                      out_ready_i,
  output logic [`FPS_WIDTH-1:0]          result_o,
  output fpslice_pkg::status_t           status_o,
  output logic [`FPS_TAG_WIDTH-1:0]      tag_o,
  output logic                           out_valid_o,
  output logic                           busy_o
);

  localparam int unsigned HW = `FPS_HALF_WIDTH;

  fpslice_pkg::lane_aux_t                     res_aux;
  logic                                       res_vector;
  logic                                       res_fp32;
  logic [`FPS_NUM_LANES-1:0]                  lane_used;
  fpslice_pkg::status_t [`FPS_NUM_LANES-1:0]  lane_status;
  logic [HW-1:0]                              upper_half;

  // Lane 0 carries the format information for the whole word
  assign res_aux    = lane0_i.aux;
  assign res_vector = res_aux.vector;
  assign res_fp32   = (res_aux.fmt == fpslice_pkg::FP32);

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  assign lane0_i.ready = out_ready_i;
  // Upper lane only pops for vector results
  assign lane1_i.ready = out_ready_i & res_vector;

  assign lane_used[0] = lane0_i.valid;
  assign lane_used[1] = lane1_i.valid & res_vector;

  assign out_valid_o = lane0_i.valid;
  assign tag_o       = lane0_i.tag;
  assign busy_o      = lane0_i.busy | lane1_i.busy;

  // ----------------------------------------
  // Result packing
  // ----------------------------------------
  // Unused upper half is NaN-boxed
  assign upper_half = lane_used[1] ? lane1_i.result[HW-1:0] : {HW{1'b1}};

  assign result_o = res_fp32 ? lane0_i.result : {upper_half, lane0_i.result[HW-1:0]};

  // Collapse the flags of all lanes in use
  assign lane_status[0] = lane_used[0] ? lane0_i.status : '0;
  assign lane_status[1] = lane_used[1] ? lane1_i.status : '0;

  always_comb begin
    status_o = '0;
    for (int i = 0; i < `FPS_NUM_LANES; i++) begin
      status_o = status_o | lane_status[i];
    end
  end

endmodule

`default_nettype wire

//--- logic/fpslice_pkg.sv
// Types shared by the FP slice modules; referenced by scoped name from each file
`default_nettype none

package fpslice_pkg;

  // ----------------------------------------
  // Formats and operations
  // ----------------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    MIN   = 3'd3,
    MAX   = 3'd4
  } operation_e;

  // ----------------------------------------
  // Status and side data
  // ----------------------------------------
  // IEEE exception flags, only NV can fire in this group
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Travels with lane 0 so the packer knows how to assemble the word
  typedef struct packed {
    fp_format_e fmt;
    logic       vector;
  } lane_aux_t;

endpackage

`default_nettype wire

//--- logic/fpslice_top.sv
// Top level of the two-lane FP slice; connects dispatcher, lanes and packer
`timescale 1ns/1ps
`default_nettype none

`include "fpslice_macros.svh"

module fpslice_top (
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  // Request
  input  wire logic [`FPS_WIDTH-1:0]     operand_a_i,
  input  wire logic [`FPS_WIDTH-1:0]     operand_b_i,
  input  wire fpslice_pkg::operation_e   op_i,
  input  wire fpslice_pkg::fp_format_e   fmt_i,
  input  wire logic                      vector_i,
  input  wire logic [`FPS_TAG_WIDTH-1:0] tag_i,
  input  wire logic                      in_valid_i,
  output logic                           in_ready_o,
  input  wire logic                      flush_i,
  // Response
  output logic [`FPS_WIDTH-1:0]          result_o,
  output fpslice_pkg::status_t           status_o,
  output logic [`FPS_TAG_WIDTH-1:0]      tag_o,
  output logic                           out_valid_o,
  input  wire logic                      out_ready_i,
  output logic                           busy_o
);

  fpslice_lane_req_if u_req0 ();
  fpslice_lane_req_if u_req1 ();
  fpslice_lane_rsp_if u_rsp0 ();
  fpslice_lane_rsp_if u_rsp1 ();

  // ----------------------------------------
  // Input side
  // ----------------------------------------
  fpslice_dispatch u_dispatch (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .vector_i    (vector_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .lane0_o     (u_req0.source),
    .lane1_o     (u_req1.source)
  );

  // ----------------------------------------
  // Lanes
  // ----------------------------------------
  fpslice_lane #(.Fp32Capable(1'b1)) u_lane0 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .req_i    (u_req0.sink),
    .rsp_o    (u_rsp0.source)
  );

  fpslice_lane #(.Fp32Capable(1'b0)) u_lane1 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .req_i    (u_req1.sink),
    .rsp_o    (u_rsp1.source)
  );

  // ----------------------------------------
  // Output side
  // ----------------------------------------
  fpslice_pack u_pack (
    .lane0_i     (u_rsp0.sink),
    .lane1_i     (u_rsp1.sink),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .busy_o      (busy_o)
  );

endmodule

`default_nettype wire

//--- src.f
+incdir+logic
logic/fpslice_pkg.sv
logic/fpslice_if.sv
logic/fpslice_dispatch.sv
logic/fpslice_lane.sv
logic/fpslice_pack.sv
logic/fpslice_top.sv
+incdir+test
test/fpslice_chk.sv
test/fpslice_tb.sv

//--- test/fpslice_chk.sv
// Output protocol assertions for the FP slice; bound into the top level for simulation
`timescale 1ns/1ps
`default_nettype none

`include "fpslice_macros.svh"

module fpslice_chk (
  input wire logic                  clk_i,
  input wire logic                  arst_n_i,
  input wire logic                  flush_i,
  input wire logic                  out_valid_i,
  input wire logic                  out_ready_i,
  input wire logic [`FPS_WIDTH-1:0] result_i,
  input wire logic                  busy_i
);

  // A stalled response keeps valid and data until taken
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && $stable(result_i))
    else $error("output valid or result changed while stalled");

  a_valid_busy: assert property (@(posedge clk_i) out_valid_i |-> busy_i)
    else $error("output valid without busy");

  a_reset_idle: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_i && !busy_i)
    else $error("output valid or busy during reset");

endmodule

bind fpslice_top fpslice_chk u_chk (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .flush_i     (flush_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_i    (result_o),
  .busy_i      (busy_o)
);

`default_nettype wire

//--- test/fpslice_cases.svh
// Case table for the FP slice testbench; included inside the testbench module body
`ifndef FPSLICE_CASES_SVH
`define FPSLICE_CASES_SVH

// Columns: name, op, fmt, vector, operand a, operand b, expected result, expected status
task automatic fill_case_table();
  // ----------------------------------------
  // FP32 scalar
  // ----------------------------------------
  add_case("sgnj32", fpslice_pkg::SGNJ, fpslice_pkg::FP32, 1'b0,
           32'h3fc0_0000, 32'hbf80_0000, 32'hbfc0_0000, ST_NONE);
  add_case("sgnjn32", fpslice_pkg::SGNJN, fpslice_pkg::FP32, 1'b0,
           32'h3fc0_0000, 32'hbf80_0000, 32'h3fc0_0000, ST_NONE);
  add_case("sgnjx32", fpslice_pkg::SGNJX, fpslice_pkg::FP32, 1'b0,
           32'hc000_0000, 32'hbf80_0000, 32'h4000_0000, ST_NONE);
  // Sign injection passes a NaN payload through untouched
  add_case("sgnj32_nan", fpslice_pkg::SGNJ, fpslice_pkg::FP32, 1'b0,
           32'h7fc0_0000, 32'h8000_0000, 32'hffc0_0000, ST_NONE);
  add_case("min32", fpslice_pkg::MIN, fpslice_pkg::FP32, 1'b0,
           32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000, ST_NONE);
  add_case("max32_neg", fpslice_pkg::MAX, fpslice_pkg::FP32, 1'b0,
           32'hbf80_0000, 32'hc000_0000, 32'hbf80_0000, ST_NONE);
  add_case("min32_zero", fpslice_pkg::MIN, fpslice_pkg::FP32, 1'b0,
           32'h0000_0000, 32'h8000_0000, 32'h8000_0000, ST_NONE);
  add_case("min32_qnan", fpslice_pkg::MIN, fpslice_pkg::FP32, 1'b0,
           32'h7fc0_0000, 32'hc000_0000, 32'hc000_0000, ST_NONE);
  add_case("max32_qnan", fpslice_pkg::MAX, fpslice_pkg::FP32, 1'b0,
           32'h3f80_0000, 32'hffc0_0001, 32'h3f80_0000, ST_NONE);
  add_case("min32_2nan", fpslice_pkg::MIN, fpslice_pkg::FP32, 1'b0,
           32'h7fc1_2345, 32'hffc0_0000, 32'h7fc0_0000, ST_NONE);
  add_case("max32_snan", fpslice_pkg::MAX, fpslice_pkg::FP32, 1'b0,
           32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000, ST_NV);
  add_case("min32_snan2", fpslice_pkg::MIN, fpslice_pkg::FP32, 1'b0,
           32'h7fc0_0000, 32'h7f80_0001, 32'h7fc0_0000, ST_NV);

  // ----------------------------------------
  // FP16 scalar and vector
  // ----------------------------------------
  add_case("sgnj16", fpslice_pkg::SGNJ, fpslice_pkg::FP16, 1'b0,
           32'hffff_3e00, 32'hffff_bc00, 32'hffff_be00, ST_NONE);
  // Unboxed a reads as the canonical NaN
  add_case("max16_unbox", fpslice_pkg::MAX, fpslice_pkg::FP16, 1'b0,
           32'h0000_3c00, 32'hffff_c000, 32'hffff_c000, ST_NONE);
  add_case("max16_snan", fpslice_pkg::MAX, fpslice_pkg::FP16, 1'b0,
           32'hffff_7c01, 32'hffff_3c00, 32'hffff_3c00, ST_NV);
  add_case("vsgnjx", fpslice_pkg::SGNJX, fpslice_pkg::FP16, 1'b1,
           32'hc000_3c00, 32'hbc00_bc00, 32'h4000_bc00, ST_NONE);
  add_case("vmax_zero", fpslice_pkg::MAX, fpslice_pkg::FP16, 1'b1,
           32'h8000_4000, 32'h0000_3c00, 32'h0000_4000, ST_NONE);
  add_case("vmin_snan_hi", fpslice_pkg::MIN, fpslice_pkg::FP16, 1'b1,
           32'h7c01_3c00, 32'h3c00_4000, 32'h3c00_3c00, ST_NV);
  add_case("vmin_snan_lo", fpslice_pkg::MIN, fpslice_pkg::FP16, 1'b1,
           32'h3c00_4000, 32'hc000_7c01, 32'hc000_4000, ST_NV);
  // Vector flag has no effect on FP32
  add_case("vec_fp32", fpslice_pkg::MAX, fpslice_pkg::FP32, 1'b1,
           32'h3f80_0000, 32'h4000_0000, 32'h4000_0000, ST_NONE);
endtask

`endif

//--- test/fpslice_tb.sv
// Testbench for the FP slice; runs the case table with and without stalls, then a flush
`timescale 1ns/1ps
`default_nettype none

`include "fpslice_macros.svh"

module fpslice_tb;

  localparam fpslice_pkg::status_t ST_NONE = 5'b00000;
  localparam fpslice_pkg::status_t ST_NV   = 5'b10000;
  localparam int LATENCY = `FPS_PIPE_REGS;

  logic                      clk_i;
  logic                      arst_n_i;
  logic [`FPS_WIDTH-1:0]     operand_a_i;
  logic [`FPS_WIDTH-1:0]     operand_b_i;
  fpslice_pkg::operation_e   op_i;
  fpslice_pkg::fp_format_e   fmt_i;
  logic                      vector_i;
  logic [`FPS_TAG_WIDTH-1:0] tag_i;
  logic                      in_valid_i;
  logic                      in_ready_o;
  logic                      flush_i;
  logic [`FPS_WIDTH-1:0]     result_o;
  fpslice_pkg::status_t      status_o;
  logic [`FPS_TAG_WIDTH-1:0] tag_o;
  logic                      out_valid_o;
  logic                      out_ready_i;
  logic                      busy_o;

  // Case table with one entry per index
  string                   case_name[$];
  fpslice_pkg::operation_e case_op[$];
  fpslice_pkg::fp_format_e case_fmt[$];
  logic                    case_vec[$];
  logic [`FPS_WIDTH-1:0]   case_a[$];
  logic [`FPS_WIDTH-1:0]   case_b[$];
  logic [`FPS_WIDTH-1:0]   case_res[$];
  fpslice_pkg::status_t    case_st[$];

  // Accepted items in issue order and their accept edges
  int          pending_idx[$];
  int          pending_cycle[$];
  int          cycle_count = 0;
  int          timeout_limit = 0;
  integer      seed;
  logic [31:0] rnd;

  task automatic add_case(input string name, input fpslice_pkg::operation_e op,
                          input fpslice_pkg::fp_format_e fmt, input logic vec,
                          input logic [`FPS_WIDTH-1:0] a, input logic [`FPS_WIDTH-1:0] b,
                          input logic [`FPS_WIDTH-1:0] res, input fpslice_pkg::status_t st);
    case_name.push_back(name);
    case_op.push_back(op);
    case_fmt.push_back(fmt);
    case_vec.push_back(vec);
    case_a.push_back(a);
    case_b.push_back(b);
    case_res.push_back(res);
    case_st.push_back(st);
  endtask

  `include "fpslice_cases.svh"

  fpslice_top u_dut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .vector_i    (vector_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count > timeout_limit) begin
      report_failure("Timeout, results stopped arriving at the output");
    end
  end

  // ----------------------------------------
  // Reporting and compare tasks
  // ----------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_result(input string name, input logic [`FPS_WIDTH-1:0] expected,
                              input logic [`FPS_WIDTH-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s result expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_status(input string name, input fpslice_pkg::status_t expected,
                              input fpslice_pkg::status_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s status expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_tag(input string name, input logic [`FPS_TAG_WIDTH-1:0] expected,
                           input logic [`FPS_TAG_WIDTH-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s tag expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      report_failure($sformatf("ERROR %s latency expected %0d actual %0d", name, expected,
                               actual));
    end
  endtask

  // ----------------------------------------
  // Driver and collector
  // ----------------------------------------
  // Holds the entry on the inputs until the accept edge
  task automatic issue_entry(input int idx, input logic [`FPS_TAG_WIDTH-1:0] tag);
    @(negedge clk_i);
    operand_a_i = case_a[idx];
    operand_b_i = case_b[idx];
    op_i        = case_op[idx];
    fmt_i       = case_fmt[idx];
    vector_i    = case_vec[idx];
    tag_i       = tag;
    in_valid_i  = 1'b1;
    #1;
    while (!in_ready_o) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic drive_table();
    for (int i = 0; i < case_name.size(); i++) begin
      issue_entry(i, i[`FPS_TAG_WIDTH-1:0]);
      pending_idx.push_back(i);
      pending_cycle.push_back(cycle_count + 1);
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic collect_table(input bit stall);
    int received;
    int idx;
    int acc;
    received = 0;
    while (received < case_name.size()) begin
      @(negedge clk_i);
      if (stall) begin
        rnd         = $random(seed);
        out_ready_i = rnd[0];
      end else begin
        out_ready_i = 1'b1;
      end
      #1;
      if (out_valid_o && out_ready_i) begin
        if (pending_idx.size() == 0) begin
          report_failure("A result came out with no operation in flight");
        end
        idx = pending_idx.pop_front();
        acc = pending_cycle.pop_front();
        check_tag(case_name[idx], idx[`FPS_TAG_WIDTH-1:0], tag_o);
        check_result(case_name[idx], case_res[idx], result_o);
        check_status(case_name[idx], case_st[idx], status_o);
        if (!stall) begin
          check_latency(case_name[idx], LATENCY, cycle_count + 1 - acc);
        end
        received++;
      end
    end
    @(negedge clk_i);
    out_ready_i = 1'b0;
    #1;
    if (out_valid_o || busy_o) begin
      report_failure("The pipeline still holds items after every result arrived");
    end
  endtask

  // Vector entries so that both lanes hold items when the flush hits
  task automatic run_flush_test();
    issue_entry(15, 8'he0);
    issue_entry(16, 8'he1);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    #1;
    if (out_valid_o || busy_o) begin
      report_failure("Flush left an item in the pipeline");
    end
    issue_entry(17, 8'he2);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    #1;
    while (!out_valid_o) begin
      @(negedge clk_i);
      #1;
    end
    check_tag("flush_next", 8'he2, tag_o);
    check_result("flush_next", case_res[17], result_o);
    check_status("flush_next", case_st[17], status_o);
    @(negedge clk_i);
    #1;
    if (out_valid_o) begin
      report_failure("A flushed item came out after the flush");
    end
  endtask

  initial begin
    seed        = 32'ha7fc_8781;
    arst_n_i    = 1'b1;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = fpslice_pkg::SGNJ;
    fmt_i       = fpslice_pkg::FP32;
    vector_i    = 1'b0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b0;
    fill_case_table();
    timeout_limit = (case_name.size() * 2 + 10) * 8;

    #1;
    arst_n_i = 1'b0;
    repeat (3) @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    if (!in_ready_o) begin
      report_failure("in_ready_o is low after reset");
    end

    // Free-flowing pass and then a pass with random stalls
    fork
      drive_table();
      collect_table(1'b0);
    join
    fork
      drive_table();
      collect_table(1'b1);
    join
    run_flush_test();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire
